/* Makefile */
# Verilator build of the core testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= core_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

/* common/core_pkg.sv */
package core_pkg;

    // datapath and address width
    localparam int XLEN = 32;
    localparam int REG_IDX_W = 5;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // 3R-type and break opcodes, inst[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;
    localparam logic [16:0] OPC_BREAK = 17'h00054;

    // 2RI12-type opcode, inst[31:22]
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;

    // 1RI20-type opcode, inst[31:25]
    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

    // operand field positions
    localparam int RD_LSB   = 0;
    localparam int RJ_LSB   = 5;
    localparam int RK_LSB   = 10;
    localparam int SI12_LSB = 10;
    localparam int SI12_W   = 12;
    localparam int SI20_LSB = 5;
    localparam int SI20_W   = 20;

    // alu operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_SRC2
    } alu_op_t;

    // fetch to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_bus_t;

    // decode to execute
    typedef struct packed {
        alu_op_t              op;
        logic [XLEN-1:0]      src1;
        logic [XLEN-1:0]      src2;
        logic                 wreg_en;
        logic [REG_IDX_W-1:0] wdest;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      inst;
        logic                 is_break;
    } ex_bus_t;

    // retired instruction record, same field order as the difftest bus
    typedef struct packed {
        logic                 is_break;
        logic [REG_IDX_W-1:0] wdest;
        logic                 wreg_en;
        logic [XLEN-1:0]      inst;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      wdata;
    } commit_t;

    // one pending register result
    typedef struct packed {
        logic                 en;
        logic [REG_IDX_W-1:0] index;
        logic [XLEN-1:0]      data;
    } bypass_t;

endpackage

/* core_top.f */
common/core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/regfile.sv
hdl/bypass_unit.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
test/tb_core_top.sv

/* hdl/bypass_unit.sv */
`timescale 1ns/100ps

module bypass_unit (
    input  logic [core_pkg::REG_IDX_W-1:0] rj_index,
    input  logic [core_pkg::REG_IDX_W-1:0] rk_index,
    input  logic [core_pkg::XLEN-1:0]      rf_rj_data,
    input  logic [core_pkg::XLEN-1:0]      rf_rk_data,
    input  core_pkg::bypass_t              ex_bypass,
    input  core_pkg::bypass_t              wb_bypass,
    output logic [core_pkg::XLEN-1:0]      rj_data,
    output logic [core_pkg::XLEN-1:0]      rk_data
);
    import core_pkg::*;

    // newest result wins, execute is younger than writeback
    function automatic logic [XLEN-1:0] pick(
        input logic [REG_IDX_W-1:0] idx,
        input logic [XLEN-1:0]      rf_val,
        input bypass_t              ex_b,
        input bypass_t              wb_b
    );
        if (ex_b.en && ex_b.index == idx) begin
            return ex_b.data;
        end else if (wb_b.en && wb_b.index == idx) begin
            return wb_b.data;
        end
        // no pending writer, file value is current
        return rf_val;
    endfunction

    // en is never set for r0, so index 0 falls through to the file
    always_comb begin
        rj_data = pick(rj_index, rf_rj_data, ex_bypass, wb_bypass);
        rk_data = pick(rk_index, rf_rk_data, ex_bypass, wb_bypass);
    end

endmodule

/* hdl/core_top.sv */
`timescale 1ns/100ps

module core_top (
    input  logic                      clk,
    input  logic                      rst,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic                      pc_valid,
    input  logic [core_pkg::XLEN-1:0] inst,
    input  logic                      inst_ready,
    output logic                      commit_valid,
    output core_pkg::commit_t         commit,
    output logic                      halted
);
    import core_pkg::*;

    // fetch to decode
    logic if_valid;
    logic if_ready;
    logic fetch_stop;
    fetch_bus_t if_bus;

    // register reads, raw and forwarded
    logic [REG_IDX_W-1:0] rj_index;
    logic [REG_IDX_W-1:0] rk_index;
    logic [XLEN-1:0] rf_rj_data;
    logic [XLEN-1:0] rf_rk_data;
    logic [XLEN-1:0] rj_data;
    logic [XLEN-1:0] rk_data;

    // decode to execute
    logic id_valid;
    ex_bus_t id_bus;

    // execute to writeback
    logic ex_valid;
    commit_t ex_bus;

    // pending results
    bypass_t ex_bypass;
    bypass_t wb_bypass;

    // register file write port
    logic wreg_en;
    logic [REG_IDX_W-1:0] wdest;
    logic [XLEN-1:0] wdata;

    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .fetch_stop (fetch_stop),
        .pc         (pc),
        .pc_valid   (pc_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .if_valid   (if_valid),
        .if_ready   (if_ready),
        .if_bus     (if_bus)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .if_valid   (if_valid),
        .if_ready   (if_ready),
        .if_bus     (if_bus),
        .rj_index   (rj_index),
        .rk_index   (rk_index),
        .rj_data    (rj_data),
        .rk_data    (rk_data),
        .fetch_stop (fetch_stop),
        .id_valid   (id_valid),
        .id_bus     (id_bus)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rj_index (rj_index),
        .rk_index (rk_index),
        .rj_data  (rf_rj_data),
        .rk_data  (rf_rk_data),
        .wreg_en  (wreg_en),
        .wdest    (wdest),
        .wdata    (wdata)
    );

    bypass_unit u_bypass (
        .rj_index   (rj_index),
        .rk_index   (rk_index),
        .rf_rj_data (rf_rj_data),
        .rf_rk_data (rf_rk_data),
        .ex_bypass  (ex_bypass),
        .wb_bypass  (wb_bypass),
        .rj_data    (rj_data),
        .rk_data    (rk_data)
    );

    execute_stage u_execute (
        .clk       (clk),
        .rst       (rst),
        .id_valid  (id_valid),
        .id_bus    (id_bus),
        .ex_bypass (ex_bypass),
        .ex_valid  (ex_valid),
        .ex_bus    (ex_bus)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .rst          (rst),
        .ex_valid     (ex_valid),
        .ex_bus       (ex_bus),
        .wb_bypass    (wb_bypass),
        .wreg_en      (wreg_en),
        .wdest        (wdest),
        .wdata        (wdata),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halted       (halted)
    );

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           if_valid,
    output logic                           if_ready,
    input  core_pkg::fetch_bus_t           if_bus,
    output logic [core_pkg::REG_IDX_W-1:0] rj_index,
    output logic [core_pkg::REG_IDX_W-1:0] rk_index,
    input  logic [core_pkg::XLEN-1:0]      rj_data,
    input  logic [core_pkg::XLEN-1:0]      rk_data,
    output logic                           fetch_stop,
    output logic                           id_valid,
    output core_pkg::ex_bus_t              id_bus
);
    import core_pkg::*;

    // execute never stalls
    logic ex_ready;
    logic accept;
    logic break_seen;
    logic known;
    logic [XLEN-1:0] inst_w;
    logic [REG_IDX_W-1:0] rd;
    logic [16:0] op17;
    logic [9:0] op10;
    logic [6:0] op7;
    logic [XLEN-1:0] si12_ext;
    logic [XLEN-1:0] si20_shift;
    ex_bus_t dec;

    assign ex_ready = 1'b1;
    assign if_ready = !id_valid || ex_ready;
    assign accept = if_valid && if_ready;

    // instruction fields
    assign inst_w = if_bus.inst;
    assign op17 = inst_w[31:15];
    assign op10 = inst_w[31:22];
    assign op7 = inst_w[31:25];
    assign rd = inst_w[RD_LSB +: REG_IDX_W];
    assign rj_index = inst_w[RJ_LSB +: REG_IDX_W];
    assign rk_index = inst_w[RK_LSB +: REG_IDX_W];

    // immediates
    assign si12_ext = {{(XLEN-SI12_W){inst_w[SI12_LSB+SI12_W-1]}}, inst_w[SI12_LSB +: SI12_W]};
    assign si20_shift = {inst_w[SI20_LSB +: SI20_W], {(XLEN-SI20_W){1'b0}}};

    always_comb begin
        dec.op       = ALU_ADD;
        dec.src1     = rj_data;
        dec.src2     = rk_data;
        dec.wdest    = rd;
        dec.pc       = if_bus.pc;
        dec.inst     = inst_w;
        dec.is_break = 1'b0;
        known        = 1'b1;
        if (op17 == OPC_ADD_W) begin
            dec.op = ALU_ADD;
        end else if (op17 == OPC_SUB_W) begin
            dec.op = ALU_SUB;
        end else if (op17 == OPC_AND) begin
            dec.op = ALU_AND;
        end else if (op17 == OPC_OR) begin
            dec.op = ALU_OR;
        end else if (op17 == OPC_XOR) begin
            dec.op = ALU_XOR;
        end else if (op17 == OPC_BREAK) begin
            dec.is_break = 1'b1;
        end else if (op10 == OPC_ADDI_W) begin
            dec.src2 = si12_ext;
        end else if (op7 == OPC_LU12I_W) begin
            dec.op   = ALU_PASS_SRC2;
            dec.src2 = si20_shift;
        end else begin
            // unknown word retires as a no-op
            known = 1'b0;
        end
        dec.wreg_en = known && !dec.is_break && (rd != '0);
    end

    // words behind a break are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid   <= 1'b0;
            break_seen <= 1'b0;
        end else begin
            id_valid <= accept && !break_seen;
            if (accept && dec.is_break) begin
                break_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_bus <= dec;
        end
    end

    assign fetch_stop = break_seen;

    // after the break itself, nothing more is issued
    no_issue_after_break_a: assert property (@(posedge clk) disable iff (rst)
        break_seen && !(id_valid && id_bus.is_break) |-> !id_valid);

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              id_valid,
    input  core_pkg::ex_bus_t id_bus,
    output core_pkg::bypass_t ex_bypass,
    output logic              ex_valid,
    output core_pkg::commit_t ex_bus
);
    import core_pkg::*;

    logic [XLEN-1:0] result;

    // 32-bit integer alu
    always_comb begin
        case (id_bus.op)
            ALU_ADD: begin
                result = id_bus.src1 + id_bus.src2;
            end
            ALU_SUB: begin
                result = id_bus.src1 - id_bus.src2;
            end
            ALU_AND: begin
                result = id_bus.src1 & id_bus.src2;
            end
            ALU_OR: begin
                result = id_bus.src1 | id_bus.src2;
            end
            ALU_XOR: begin
                result = id_bus.src1 ^ id_bus.src2;
            end
            default: begin
                // lu12i.w, immediate already shifted by decode
                result = id_bus.src2;
            end
        endcase
    end

    // result visible to decode in the same cycle
    assign ex_bypass.en = id_valid && id_bus.wreg_en;
    assign ex_bypass.index = id_bus.wdest;
    assign ex_bypass.data = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    // commit record for writeback
    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_bus.is_break <= id_bus.is_break;
            ex_bus.wdest    <= id_bus.wdest;
            ex_bus.wreg_en  <= id_bus.wreg_en;
            ex_bus.inst     <= id_bus.inst;
            ex_bus.pc       <= id_bus.pc;
            ex_bus.wdata    <= result;
        end
    end

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_stop,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic                      pc_valid,
    input  logic [core_pkg::XLEN-1:0] inst,
    input  logic                      inst_ready,
    output logic                      if_valid,
    input  logic                      if_ready,
    output core_pkg::fetch_bus_t      if_bus
);
    import core_pkg::*;

    // low through reset, high from the first cycle after it
    logic fetch_en;
    // pc and inst handed over this cycle
    logic xfer;

    // request only while the fetch register is free or draining
    assign pc_valid = fetch_en && (!if_valid || if_ready) && !fetch_stop;
    assign xfer = pc_valid && inst_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_en <= 1'b0;
            pc       <= RESET_PC;
            if_valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (xfer) begin
                // sequential fetch only, no branches
                pc       <= pc + XLEN'(4);
                if_valid <= 1'b1;
            end else if (if_ready) begin
                if_valid <= 1'b0;
            end
        end
    end

    // fetched word and its address
    always_ff @(posedge clk) begin
        if (xfer) begin
            if_bus.pc   <= pc;
            if_bus.inst <= inst;
        end
    end

    // instruction port, address held until accepted
    pc_hold_a: assert property (@(posedge clk) disable iff (rst)
        pc_valid && !inst_ready |=> $stable(pc));

endmodule

/* hdl/regfile.sv */
`timescale 1ns/100ps

module regfile (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [core_pkg::REG_IDX_W-1:0] rj_index,
    input  logic [core_pkg::REG_IDX_W-1:0] rk_index,
    output logic [core_pkg::XLEN-1:0]      rj_data,
    output logic [core_pkg::XLEN-1:0]      rk_data,
    input  logic                           wreg_en,
    input  logic [core_pkg::REG_IDX_W-1:0] wdest,
    input  logic [core_pkg::XLEN-1:0]      wdata
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [1 << REG_IDX_W];

    // r0 hardwired, same-cycle write passed straight to the reader
    function automatic logic [XLEN-1:0] read_port(input logic [REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (wreg_en && wdest == idx) begin
            return wdata;
        end
        return regs[idx];
    endfunction

    // architectural registers start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << REG_IDX_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wreg_en && wdest != '0) begin
            regs[wdest] <= wdata;
        end
    end

    always_comb begin
        rj_data = read_port(rj_index);
        rk_data = read_port(rk_index);
    end

endmodule

/* hdl/writeback_stage.sv */
`timescale 1ns/100ps

module writeback_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ex_valid,
    input  core_pkg::commit_t              ex_bus,
    output core_pkg::bypass_t              wb_bypass,
    output logic                           wreg_en,
    output logic [core_pkg::REG_IDX_W-1:0] wdest,
    output logic [core_pkg::XLEN-1:0]      wdata,
    output logic                           commit_valid,
    output core_pkg::commit_t              commit,
    output logic                           halted
);

    // record entering writeback, not yet in the register file
    assign wb_bypass.en = ex_valid && ex_bus.wreg_en;
    assign wb_bypass.index = ex_bus.wdest;
    assign wb_bypass.data = ex_bus.wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            commit_valid <= ex_valid;
            // sticky until reset
            if (ex_valid && ex_bus.is_break) begin
                halted <= 1'b1;
            end
        end
    end

    // one cycle delay, like the difftest bus
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            commit <= ex_bus;
        end
    end

    // file written from the committed record
    assign wreg_en = commit_valid && commit.wreg_en;
    assign wdest = commit.wdest;
    assign wdata = commit.wdata;

    // decode clears wreg_en for rd == r0
    no_r0_write_a: assert property (@(posedge clk) disable iff (rst)
        commit_valid && commit.wreg_en |-> commit.wdest != '0);

endmodule

/* test/tb_core_top.sv */
`timescale 1ns/100ps

module tb_core_top;
    import core_pkg::*;

    localparam int PROG_LEN = 200;
    localparam int RESET_CYCLES = 3;
    localparam int START_TIMEOUT = 20;
    localparam int HALT_TIMEOUT = 5000;
    localparam int QUIET_CYCLES = 50;
    localparam logic [31:0] LFSR_SEED = 32'h07f4_0ec1;
    // x^32 + x^22 + x^2 + x + 1, right shifting form
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clk;
    logic rst;
    logic [31:0] pc;
    logic pc_valid;
    logic [31:0] inst;
    logic inst_ready;
    logic commit_valid;
    commit_t commit;
    logic halted;

    logic [31:0] lfsr_state;
    logic [31:0] prog_words [256];
    // architectural state of the reference model
    logic [31:0] ref_regs [32];
    int commit_count;

    core_top DUT (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .pc_valid     (pc_valid),
        .inst         (inst),
        .inst_ready   (inst_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error %s: got %h, expected %h", name, got, want);
            stop_with_failure();
        end
    endtask

    // one lfsr step per bit, newest bit lands in bit 0
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
        end
        return bits;
    endfunction

    function automatic logic [31:0] make_word(input logic last);
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        logic [2:0] form;
        logic [31:0] word;
        if (last) begin
            word = {OPC_BREAK, 15'(take_bits(15))};
        end else if (take_bits(4) == 32'h0) begin
            // top bits all ones, matches no opcode
            word = {6'h3f, 26'(take_bits(26))};
        end else begin
            // r0..r7 only, so neighbours often depend on each other
            rd = 5'(take_bits(3));
            rj = 5'(take_bits(3));
            rk = 5'(take_bits(3));
            form = 3'(take_bits(3));
            case (form)
                3'd0: word = {OPC_ADD_W, rk, rj, rd};
                3'd1: word = {OPC_SUB_W, rk, rj, rd};
                3'd2: word = {OPC_AND, rk, rj, rd};
                3'd3: word = {OPC_OR, rk, rj, rd};
                3'd4: word = {OPC_XOR, rk, rj, rd};
                3'd5: word = {OPC_ADDI_W, 12'(take_bits(12)), rj, rd};
                default: word = {OPC_LU12I_W, 20'(take_bits(20)), rd};
            endcase
        end
        return word;
    endfunction

    // program word for an address, beyond the break a pattern from the pc
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - RESET_PC;
        if (offset < 32'(4 * PROG_LEN)) begin
            return prog_words[offset[9:2]];
        end
        return ~addr;
    endfunction

    // executes one word on ref_regs, gives the commit it should produce
    function automatic commit_t predict_commit(input logic [31:0] pc_in,
                                               input logic [31:0] word);
        commit_t rec;
        logic [4:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic known;
        rd = word[4:0];
        a = ref_regs[word[9:5]];
        b = ref_regs[word[14:10]];
        res = '0;
        known = 1'b1;
        rec.is_break = 1'b0;
        if (word[31:15] == OPC_ADD_W) begin
            res = a + b;
        end else if (word[31:15] == OPC_SUB_W) begin
            res = a - b;
        end else if (word[31:15] == OPC_AND) begin
            res = a & b;
        end else if (word[31:15] == OPC_OR) begin
            res = a | b;
        end else if (word[31:15] == OPC_XOR) begin
            res = a ^ b;
        end else if (word[31:15] == OPC_BREAK) begin
            rec.is_break = 1'b1;
            known = 1'b0;
        end else if (word[31:22] == OPC_ADDI_W) begin
            res = a + {{20{word[21]}}, word[21:10]};
        end else if (word[31:25] == OPC_LU12I_W) begin
            res = {word[24:5], 12'h000};
        end else begin
            known = 1'b0;
        end
        rec.pc = pc_in;
        rec.inst = word;
        rec.wreg_en = known && (rd != 5'd0);
        rec.wdest = rd;
        rec.wdata = res;
        // r0 never written, stays zero
        if (rec.wreg_en) begin
            ref_regs[rd] = res;
        end
        return rec;
    endfunction

    // instruction port, answers after 0..3 cycles, may stay ready back to back
    initial begin : port_model
        int wait_left;
        logic [31:0] fetch_pc;
        wait_left = 0;
        fetch_pc = RESET_PC;
        forever begin
            @(posedge clk);
            if (rst) begin
                inst_ready <= 1'b0;
                fetch_pc = RESET_PC;
                wait_left = int'(take_bits(2));
            end else if (pc_valid && inst_ready) begin
                check_value("pc", pc, fetch_pc);
                fetch_pc = fetch_pc + 32'd4;
                wait_left = int'(take_bits(2));
                if (wait_left == 0) begin
                    inst <= fetch_word(fetch_pc);
                end else begin
                    inst_ready <= 1'b0;
                end
            end else if (pc_valid) begin
                // held request, pc must not move
                check_value("pc", pc, fetch_pc);
                if (wait_left == 0) begin
                    inst <= fetch_word(fetch_pc);
                    inst_ready <= 1'b1;
                end else begin
                    wait_left--;
                end
            end else begin
                inst_ready <= 1'b0;
            end
        end
    end

    // every commit in program order against the reference
    initial begin : commit_checker
        commit_t rec;
        logic [31:0] exp_pc;
        exp_pc = RESET_PC;
        forever begin
            @(posedge clk);
            if (rst) begin
                exp_pc = RESET_PC;
            end else if (commit_valid) begin
                if (commit_count >= PROG_LEN) begin
                    $display("a commit arrived after the break had retired");
                    stop_with_failure();
                end else begin
                    rec = predict_commit(exp_pc, fetch_word(exp_pc));
                    check_value("commit.pc", commit.pc, rec.pc);
                    check_value("commit.inst", commit.inst, rec.inst);
                    check_value("commit.wreg_en", 32'(commit.wreg_en), 32'(rec.wreg_en));
                    check_value("commit.is_break", 32'(commit.is_break), 32'(rec.is_break));
                    // halted rises on the same edge as the break commit
                    check_value("halted", 32'(halted), 32'(rec.is_break));
                    if (rec.wreg_en) begin
                        check_value("commit.wdest", 32'(commit.wdest), 32'(rec.wdest));
                        check_value("commit.wdata", commit.wdata, rec.wdata);
                    end
                    exp_pc = exp_pc + 32'd4;
                    commit_count++;
                end
            end
        end
    end

    initial begin : main_flow
        int waited;
        rst <= 1'b1;
        inst <= '0;
        inst_ready <= 1'b0;
        lfsr_state = LFSR_SEED;
        commit_count = 0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r[4:0]] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            prog_words[i[7:0]] = make_word(i == PROG_LEN - 1);
        end

        // outputs quiet once the first reset edge is through
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c > 0) begin
                check_value("pc_valid", 32'(pc_valid), 32'h0);
                check_value("commit_valid", 32'(commit_valid), 32'h0);
                check_value("halted", 32'(halted), 32'h0);
            end
        end
        rst <= 1'b0;

        waited = 0;
        while (!pc_valid && waited < START_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!pc_valid) begin
            $display("timeout, pc_valid never rose after reset");
            stop_with_failure();
        end
        check_value("pc", pc, RESET_PC);

        waited = 0;
        while (!halted && waited < HALT_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!halted) begin
            $display("timeout, the core never halted");
            stop_with_failure();
        end

        // stopped core, no requests and no commits
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            @(posedge clk);
            check_value("commit_valid", 32'(commit_valid), 32'h0);
            check_value("pc_valid", 32'(pc_valid), 32'h0);
            check_value("halted", 32'(halted), 32'h1);
        end
        check_value("commit_count", 32'(commit_count), 32'(PROG_LEN));
        $display("TEST OK");
        $finish;
    end

endmodule
